// ==== verilog/mips_defs.svh ====
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// Datapath sizing
//////////////////////////////////////////////////////////////////////

`define MIPS_WORD_W   32        // Data word width
`define MIPS_NREGS    32        // Architectural registers
`define MIPS_RA_W     5         // Bits in a register index

//////////////////////////////////////////////////////////////////////
// Reset state
//////////////////////////////////////////////////////////////////////

// Stack pointer is $29 in the MIPS ABI
`define MIPS_REG_SP   29

// Initial stack top
`define MIPS_SP_INIT  32'h200

`endif

// ==== verilog/mips_pkg.sv ====
`include "mips_defs.svh"

package mips_pkg;

    // Basic datapath types
    typedef logic [`MIPS_WORD_W-1:0] word_t;    // One data word
    typedef logic [`MIPS_RA_W-1:0]   reg_addr_t; // Register index

    //////////////////////////////////////////////////////////////////////
    // ALU operations, shared by decoder and ALU
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,   // a + b, no overflow trap
        ALU_SUB   = 4'd1,   // a - b
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_SLT   = 4'd4,   // Signed less-than
        ALU_MULTU = 4'd5,   // Product into HI:LO
        ALU_DIVU  = 4'd6,   // Remainder to HI, quotient to LO
        ALU_MFHI  = 4'd7,
        ALU_MFLO  = 4'd8
    } alu_op_t;

    // Primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_ADDI  = 6'h08
    } opcode_t;

    // R-type function field, instr[5:0]
    typedef enum logic [5:0] {
        F_MFHI  = 6'h10,
        F_MFLO  = 6'h12,
        F_MULTU = 6'h19,
        F_DIVU  = 6'h1B,
        F_ADD   = 6'h20,
        F_SUB   = 6'h22,
        F_AND   = 6'h24,
        F_OR    = 6'h25,
        F_SLT   = 6'h2A
    } funct_t;

endpackage

// ==== verilog/regfile.sv ====
`timescale 1ns/1ps
`include "mips_defs.svh"

module regfile
    import mips_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      we,     // Write enable, sampled at rising edge
    input  reg_addr_t wa,
    input  word_t     wd,
    input  reg_addr_t ra0,    // rs port
    input  reg_addr_t ra1,    // rt port
    input  reg_addr_t ra2,    // Debug port
    output word_t     rd0,
    output word_t     rd1,
    output word_t     rd2
);

    word_t rf [`MIPS_NREGS];  // Register array, entry 0 never read

    //////////////////////////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NREGS; i++) begin
                rf[i] <= '0;
            end
            rf[`MIPS_REG_SP] <= `MIPS_SP_INIT;   // Stack starts here
        end else if (we && (wa != '0)) begin    // r0 writes dropped
            rf[wa] <= wd;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read ports
    //////////////////////////////////////////////////////////////////////
    // Combinational, so same-cycle write is not forwarded
    assign rd0 = (ra0 == '0) ? '0 : rf[ra0];
    assign rd1 = (ra1 == '0) ? '0 : rf[ra1];
    assign rd2 = (ra2 == '0) ? '0 : rf[ra2];  // r0 hardwired to zero

endmodule

// ==== verilog/mips_alu.sv ====
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_alu
    import mips_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  logic    valid,    // Qualifies HI/LO update
    input  alu_op_t op,
    input  word_t   a,        // rs value
    input  word_t   b,        // rt value or immediate
    output word_t   y,
    output logic    zero
);

    logic                       hilo_en;   // Load strobe for HI and LO
    word_t                      hi_d;      // Next HI
    word_t                      lo_d;      // Next LO
    word_t                      hi_q;      // Stored HI
    word_t                      lo_q;      // Stored LO
    logic [2*`MIPS_WORD_W-1:0]  product;   // Full unsigned product
    word_t                      quot;
    word_t                      rem;

    //////////////////////////////////////////////////////////////////////
    // Multiply and divide
    //////////////////////////////////////////////////////////////////////
    // Zero-extend so the product keeps all 64 bits
    assign product = {{`MIPS_WORD_W{1'b0}}, a} * {{`MIPS_WORD_W{1'b0}}, b};

    // Divide by zero yields zero for both halves
    assign quot = (b == '0) ? '0 : a / b;
    assign rem  = (b == '0) ? '0 : a % b;

    // Only MULTU and DIVU touch HI/LO
    assign hilo_en = valid && ((op == ALU_MULTU) || (op == ALU_DIVU));

    always_comb begin
        if (op == ALU_DIVU) begin
            hi_d = rem;
            lo_d = quot;
        end else begin
            {hi_d, lo_d} = product;    // MULTU, otherwise ignored
        end
    end

    // HI and LO special registers
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (hilo_en) begin
            hi_q <= hi_d;
            lo_q <= lo_d;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Result select
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        y = '0;                        // MULTU/DIVU leave y at zero
        case (op)
            ALU_ADD:  y = a + b;        // Wraps, no trap
            ALU_SUB:  y = a - b;
            ALU_AND:  y = a & b;
            ALU_OR:   y = a | b;
            ALU_SLT:  y = ($signed(a) < $signed(b)) ? word_t'(1) : '0;
            ALU_MFHI: y = hi_q;
            ALU_MFLO: y = lo_q;
            default:  y = '0;
        endcase
    end

    assign zero = (y == '0);           // Zero flag

endmodule

// ==== verilog/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode
    import mips_pkg::*;
(
    input  logic    valid,      // Instruction word is live
    input  opcode_t opcode,
    input  funct_t  funct,
    output alu_op_t alu_op,
    output logic    reg_write,  // Result goes to the register file
    output logic    dst_rt,     // Destination is rt, else rd
    output logic    use_imm,    // ALU b takes the immediate
    output logic    illegal
);

    logic bad;                  // Unknown opcode or funct

    //////////////////////////////////////////////////////////////////////
    // Opcode and function decode
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        // Defaults describe a harmless no-write add
        alu_op    = ALU_ADD;
        reg_write = 1'b0;
        dst_rt    = 1'b0;
        use_imm   = 1'b0;
        bad       = 1'b0;

        case (opcode)
            OP_RTYPE: begin
                reg_write = 1'b1;      // Most R-type ops write rd
                case (funct)
                    F_ADD:   alu_op = ALU_ADD;
                    F_SUB:   alu_op = ALU_SUB;
                    F_AND:   alu_op = ALU_AND;
                    F_OR:    alu_op = ALU_OR;
                    F_SLT:   alu_op = ALU_SLT;
                    F_MFHI:  alu_op = ALU_MFHI;
                    F_MFLO:  alu_op = ALU_MFLO;
                    F_MULTU: begin
                        alu_op    = ALU_MULTU;
                        reg_write = 1'b0;    // Writes HI/LO only
                    end
                    F_DIVU: begin
                        alu_op    = ALU_DIVU;
                        reg_write = 1'b0;    // Writes HI/LO only
                    end
                    default: begin
                        bad       = 1'b1;    // Unsupported funct
                        reg_write = 1'b0;
                    end
                endcase
            end

            OP_ADDI: begin
                alu_op    = ALU_ADD;
                reg_write = 1'b1;
                dst_rt    = 1'b1;            // I-type writes rt
                use_imm   = 1'b1;
            end

            default: begin
                bad = 1'b1;                  // Unsupported opcode
            end
        endcase
    end

    // Flag only counts for a live instruction
    assign illegal = valid && bad;

endmodule

// ==== verilog/mips_exec_core.sv ====
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_exec_core
    import mips_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      instr_valid,  // Level, one instruction per cycle
    input  word_t     instr,
    input  reg_addr_t dbg_addr,     // Debug read address
    output word_t     result,
    output logic      zero,
    output logic      illegal,
    output word_t     dbg_data
);

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rs, rt, rd;
    logic [15:0] imm;
    word_t     imm_ext;             // Sign-extended immediate
    alu_op_t   alu_op;
    logic      reg_write, dst_rt, use_imm;
    word_t     rs_val, rt_val;
    word_t     alu_b;
    reg_addr_t wa;

    //////////////////////////////////////////////////////////////////////
    // Field split and operand muxes
    //////////////////////////////////////////////////////////////////////
    assign opcode = opcode_t'(instr[31:26]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign funct  = funct_t'(instr[5:0]);
    assign imm    = instr[15:0];

    assign imm_ext = {{(`MIPS_WORD_W-16){imm[15]}}, imm};
    assign alu_b   = use_imm ? imm_ext : rt_val;  // ADDI takes immediate
    assign wa      = dst_rt ? rt : rd;            // rt for I-type

    instr_decode u_decode (
        .valid     (instr_valid),
        .opcode    (opcode),
        .funct     (funct),
        .alu_op    (alu_op),
        .reg_write (reg_write),
        .dst_rt    (dst_rt),
        .use_imm   (use_imm),
        .illegal   (illegal)
    );

    regfile u_regfile (
        .clock (clock),
        .reset (reset),
        .we    (instr_valid && reg_write),   // Commit at next edge
        .wa    (wa),
        .wd    (result),
        .ra0   (rs),
        .ra1   (rt),
        .ra2   (dbg_addr),
        .rd0   (rs_val),
        .rd1   (rt_val),
        .rd2   (dbg_data)
    );

    mips_alu u_alu (
        .clock (clock),
        .reset (reset),
        .valid (instr_valid),
        .op    (alu_op),
        .a     (rs_val),
        .b     (alu_b),
        .y     (result),
        .zero  (zero)
    );

endmodule

// ==== dv/tb_mips_vectors.svh ====
`ifndef TB_MIPS_VECTORS_SVH
`define TB_MIPS_VECTORS_SVH

// Each row holds the instruction, valid, whether result and zero are checked,
// the expected result, zero and illegal, then a debug register and its value

function automatic word_t rtype(int rs, int rt, int rd, int funct);
    return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, 6'(funct)};
endfunction

function automatic word_t itype(int op, int rs, int rt, int imm);
    return {6'(op), 5'(rs), 5'(rt), 16'(imm)};
endfunction

function automatic void add_vector(word_t iw, int valid, int check, int res, int z,
                                   int ill, int dbg, int dbg_val);
    vector_t v;
    v.instr     = iw;
    v.valid     = (valid != 0);
    v.check_res = (check != 0);
    v.res       = res;
    v.zero      = (z != 0);
    v.illegal   = (ill != 0);
    v.dbg_reg   = reg_addr_t'(dbg);
    v.dbg_val   = dbg_val;
    vectors.push_back(v);
endfunction

function automatic void build_vectors();
    add_vector(32'h0, 0, 0, 0, 0, 0, `MIPS_REG_SP, `MIPS_SP_INIT);  // Reset state
    add_vector(32'h0, 0, 0, 0, 0, 0, 8, 0);
    add_vector(itype(OP_ADDI, 0, 8, 'h0064), 1, 1, 'h64, 0, 0, 8, 'h64);
    add_vector(itype(OP_ADDI, 0, 9, 'hFFFB), 1, 1, 'hFFFF_FFFB, 0, 0, 9, 'hFFFF_FFFB);
    add_vector(itype(OP_ADDI, 29, 10, 'hFFF0), 1, 1, 'h1F0, 0, 0, 10, 'h1F0);
    add_vector(rtype(8, 10, 11, F_ADD), 1, 1, 'h254, 0, 0, 11, 'h254);
    add_vector(rtype(8, 8, 12, F_SUB), 1, 1, 0, 1, 0, 12, 0);      // Equal operands
    add_vector(rtype(8, 10, 13, F_SUB), 1, 1, 'hFFFF_FE74, 0, 0, 13, 'hFFFF_FE74);
    add_vector(rtype(11, 10, 14, F_AND), 1, 1, 'h50, 0, 0, 14, 'h50);
    add_vector(rtype(8, 10, 15, F_OR), 1, 1, 'h1F4, 0, 0, 15, 'h1F4);
    add_vector(rtype(9, 8, 16, F_SLT), 1, 1, 1, 0, 0, 16, 1);      // -5 < 100
    add_vector(rtype(8, 9, 17, F_SLT), 1, 1, 0, 1, 0, 17, 0);
    add_vector(rtype(8, 8, 0, F_ADD), 1, 1, 'hC8, 0, 0, 0, 0);     // r0 stays zero
    // Large operands for the multiply
    add_vector(itype(OP_ADDI, 0, 18, 'hFFFF), 1, 1, 'hFFFF_FFFF, 0, 0, 18, 'hFFFF_FFFF);
    add_vector(itype(OP_ADDI, 0, 19, 'h8000), 1, 1, 'hFFFF_8000, 0, 0, 19, 'hFFFF_8000);
    add_vector(rtype(18, 19, 0, F_MULTU), 1, 1, 0, 1, 0, 18, 'hFFFF_FFFF);
    add_vector(rtype(0, 0, 20, F_MFHI), 1, 1, 'hFFFF_7FFF, 0, 0, 20, 'hFFFF_7FFF);
    add_vector(rtype(0, 0, 21, F_MFLO), 1, 1, 'h8000, 0, 0, 21, 'h8000);
    add_vector(rtype(11, 8, 0, F_DIVU), 1, 1, 0, 1, 0, 11, 'h254);  // 596 / 100
    add_vector(rtype(0, 0, 22, F_MFHI), 1, 1, 'h60, 0, 0, 22, 'h60);
    add_vector(rtype(0, 0, 23, F_MFLO), 1, 1, 5, 0, 0, 23, 5);
    add_vector(rtype(8, 0, 0, F_DIVU), 1, 1, 0, 1, 0, 8, 'h64);    // Divide by zero
    add_vector(rtype(0, 0, 24, F_MFHI), 1, 1, 0, 1, 0, 24, 0);
    add_vector(rtype(0, 0, 25, F_MFLO), 1, 1, 0, 1, 0, 25, 0);
    // Unknown opcode, then unknown funct
    add_vector(itype('h3F, 8, 8, 'h4000), 1, 0, 0, 0, 1, 8, 'h64);  // rd and rt both r8
    add_vector(rtype(8, 8, 9, 'h3F), 1, 0, 0, 0, 1, 9, 'hFFFF_FFFB);
    // Idle cycles must not touch state
    add_vector(itype(OP_ADDI, 0, 8, 'h7777), 0, 0, 0, 0, 0, 8, 'h64);
    add_vector(rtype(18, 19, 0, F_MULTU), 0, 0, 0, 0, 0, 18, 'hFFFF_FFFF);
    add_vector(rtype(0, 0, 26, F_MFHI), 1, 1, 0, 1, 0, 26, 0);     // HI still zero
    add_vector(rtype(0, 0, 27, F_MFLO), 1, 1, 0, 1, 0, 27, 0);
    add_vector(itype('h3F, 0, 29, 'h0), 0, 0, 0, 0, 0, 29, `MIPS_SP_INIT);
endfunction

`endif

// ==== dv/tb_mips_exec_core.sv ====
`timescale 1ns/1ps
`include "mips_defs.svh"

module tb_mips_exec_core
    import mips_pkg::*;
();

    logic      clock;
    logic      reset;
    logic      instr_valid;
    word_t     instr;
    reg_addr_t dbg_addr;
    word_t     result;
    logic      zero;
    logic      illegal;
    word_t     dbg_data;

    typedef struct packed {
        word_t     instr;
        logic      valid;
        logic      check_res;   // Result and zero defined for this row
        word_t     res;
        logic      zero;
        logic      illegal;
        reg_addr_t dbg_reg;     // Read back in the following cycle
        word_t     dbg_val;
    } vector_t;

    vector_t vectors[$];
    bit      table_ready;

    `include "tb_mips_vectors.svh"

    mips_exec_core UUT (
        .clock       (clock),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .dbg_addr    (dbg_addr),
        .result      (result),
        .zero        (zero),
        .illegal     (illegal),
        .dbg_data    (dbg_data)
    );

    //////////////////////////////////////////////////////////////////////
    // Clock and watchdog
    //////////////////////////////////////////////////////////////////////
    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;    // 20 ns period
    end

    initial begin
        wait (table_ready);
        #((vectors.size() + 20) * 20);   // Table plus reset and slack
        report_failure("Watchdog expired, the run timed out");
    end

    task automatic report_failure(string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_value(string name, int row, word_t got, word_t exp);
        assert (got === exp) else begin
            report_failure($sformatf("[FAIL] %s row %0d got 0x%08h expected 0x%08h",
                                     name, row, got, exp));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus loop
    //////////////////////////////////////////////////////////////////////
    initial begin
        int      n;
        int      i;
        vector_t cur;

        instr_valid = 1'b0;
        instr       = '0;
        dbg_addr    = '0;
        reset       = 1'b1;
        build_vectors();
        n           = vectors.size();
        table_ready = 1'b1;

        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;

        // One extra pass at the end to read back the last row
        for (i = 0; i <= n; i++) begin
            if (i > 0) begin
                @(posedge clock);
                #1;                    // Drive just after the edge
            end
            if (i < n) begin
                cur         = vectors[i];
                instr       = cur.instr;
                instr_valid = cur.valid;
            end else begin
                instr       = '0;
                instr_valid = 1'b0;
            end
            dbg_addr = (i > 0) ? vectors[i-1].dbg_reg : '0;

            #10;                       // Mid-cycle, outputs settled
            if (i < n) begin
                check_value("illegal", i, word_t'(illegal), word_t'(cur.illegal));
                if (cur.check_res) begin
                    check_value("result", i, result, cur.res);
                    check_value("zero", i, word_t'(zero), word_t'(cur.zero));
                end
            end
            if (i > 0) begin
                check_value("dbg_data", i - 1, dbg_data, vectors[i-1].dbg_val);
            end
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+verilog
+incdir+dv
verilog/mips_pkg.sv
verilog/regfile.sv
verilog/mips_alu.sv
verilog/instr_decode.sv
verilog/mips_exec_core.sv
dv/tb_mips_exec_core.sv

// ==== Makefile ====
VERILATOR   ?= verilator
TOP         := tb_mips_exec_core
RTL_TOP     := mips_exec_core
FILELIST    := project.f
BUILD_FLAGS := --binary --timing --assert
LINT_FLAGS  := --lint-only --timing -Wall
OBJ_DIR     := obj_dir
BIN         := $(OBJ_DIR)/V$(TOP)
LOG         := sim.log
SOURCES     := $(wildcard verilog/*.sv verilog/*.svh dv/*.sv dv/*.svh)

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(BUILD_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "^NO ERRORS$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
